/* design/mem_pkg.sv */
// Shared types for the two-port line memory subsystem; 64 lines of 64 bits, bursts of 1 to 4 lines
package mem_pkg;

    // ============================================================
    // Widths and basic types
    // ============================================================

    // One memory line
    typedef logic [63:0] line_t;

    // Line address, enough for 64 lines
    typedef logic [5:0] addr_t;

    // Number of lines in a read burst minus one, so 0 means a single line
    typedef logic [1:0] len_t;

    // Rolling request tag carried through the memory and back
    typedef logic [3:0] tag_t;

    // ============================================================
    // Opcodes
    // ============================================================

    // Operation carried with every memory request and response
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // ============================================================
    // Request and response structs
    // ============================================================

    // Request from a driver, through the arbiter, to the memory
    // For reads the data field has no meaning and is ignored by the memory
    typedef struct packed {
        mem_op_e op;
        addr_t   addr;
        line_t   data;
        tag_t    tag;
        logic    last;
    } mem_req_t;

    // Response from the memory, through the arbiter, back to a driver
    // The last flag marks the final line of a read burst and is always set on writes
    typedef struct packed {
        mem_op_e op;
        line_t   data;
        tag_t    tag;
        logic    last;
    } mem_rsp_t;

    // Client read request, a start address and a line count
    typedef struct packed {
        addr_t addr;
        len_t  num_lines;
    } rd_req_t;

    // Client write request, a single line
    typedef struct packed {
        addr_t addr;
        line_t data;
    } wr_req_t;

    // ============================================================
    // Tag reset values
    // ============================================================

    // Odd starting points that do not line up with each other,
    // so a driver mixing up the two tag streams shows up quickly
    localparam tag_t READ_TAG_INIT  = tag_t'(11);
    localparam tag_t WRITE_TAG_INIT = tag_t'(5);

endpackage

/* design/line_memory.sv */
// NUM_LINES must be a power of two no larger than 64; upper address bits are ignored below that
module line_memory
#(
    parameter int NUM_LINES = 64
)
(
    input  logic              clk,
    input  logic              reset,
    input  mem_pkg::mem_req_t req,
    input  logic              req_valid,
    output mem_pkg::mem_rsp_t rsp,
    output logic              rsp_valid
);

    localparam int AW = $clog2(NUM_LINES);

    // Line storage, contents are undefined until written
    mem_pkg::line_t mem [NUM_LINES];

    logic [AW-1:0] idx;

    assign idx = req.addr[AW-1:0];

    // Storage and response payload
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            if (req.op == mem_pkg::OP_WRITE)
                mem[idx] <= req.data;
            // Reads return the stored line, writes return the old contents
            rsp.data <= mem[idx];
            rsp.op   <= req.op;
            rsp.tag  <= req.tag;
            rsp.last <= req.last;
        end
    end

    // Every request gets exactly one response one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= req_valid;
    end

endmodule

/* design/mem_driver.sv */
// One client request at a time; if rd_en and wr_en arrive together the read is taken and the write is lost
module mem_driver
#(
    parameter int BURST_MAX = 4
)
(
    input  logic             clk,
    input  logic             reset,

    // Client side
    input  mem_pkg::rd_req_t rd_req,
    input  logic             rd_en,
    input  mem_pkg::wr_req_t wr_req,
    input  logic             wr_en,
    output logic             rdy,
    output mem_pkg::line_t   rd_data,
    output logic             rd_valid,
    output logic             rd_last,
    output logic             wr_ack,
    output logic             tag_error,

    // Arbiter side
    output mem_pkg::mem_req_t req,
    output logic              req_valid,
    input  logic              grant,
    input  mem_pkg::mem_rsp_t rsp,
    input  logic              rsp_valid
);

    // Largest line count the driver will expand a read into, minus one
    localparam mem_pkg::len_t LEN_CAP = mem_pkg::len_t'(BURST_MAX - 1);

    typedef enum logic [1:0] {
        DRV_IDLE,
        DRV_READ_BURST,
        DRV_WRITE
    } drv_state_e;

    drv_state_e     state;

    // Request tags, one stream for reads and one for writes
    mem_pkg::tag_t  rd_tag;
    mem_pkg::tag_t  wr_tag;

    // Tags expected on the next read and write responses
    mem_pkg::tag_t  rd_rsp_tag;
    mem_pkg::tag_t  wr_rsp_tag;

    // Current request payload
    mem_pkg::addr_t cur_addr;
    mem_pkg::line_t wr_data;
    mem_pkg::len_t  lines_left;
    mem_pkg::len_t  burst_len;

    // ============================================================
    // Client handshake and request generation
    // ============================================================

    // Only an idle driver takes a new client request
    assign rdy = (state == DRV_IDLE);

    // Bursts longer than the configured maximum are cut down to it
    assign burst_len = (rd_req.num_lines > LEN_CAP) ? LEN_CAP : rd_req.num_lines;

    // The request is held steady until the arbiter grants it
    assign req_valid = (state != DRV_IDLE);
    assign req.op    = (state == DRV_WRITE) ? mem_pkg::OP_WRITE : mem_pkg::OP_READ;
    assign req.addr  = cur_addr;
    assign req.data  = wr_data;
    assign req.tag   = (state == DRV_WRITE) ? wr_tag : rd_tag;
    // A write is always a single line, a read is last when no lines remain
    assign req.last  = (state == DRV_WRITE) || (lines_left == '0);

    // Control state and tags
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= DRV_IDLE;
            rd_tag     <= mem_pkg::READ_TAG_INIT;
            wr_tag     <= mem_pkg::WRITE_TAG_INIT;
            rd_rsp_tag <= mem_pkg::READ_TAG_INIT;
            wr_rsp_tag <= mem_pkg::WRITE_TAG_INIT;
            tag_error  <= 1'b0;
        end
        else
        begin
            case (state)
                DRV_IDLE:
                begin
                    if (rd_en)
                        state <= DRV_READ_BURST;
                    else if (wr_en)
                        state <= DRV_WRITE;
                end
                DRV_READ_BURST:
                begin
                    // The whole burst shares one tag, advanced after its last line
                    if (grant && (lines_left == '0))
                    begin
                        state  <= DRV_IDLE;
                        rd_tag <= rd_tag + mem_pkg::tag_t'(1);
                    end
                end
                DRV_WRITE:
                begin
                    if (grant)
                    begin
                        state  <= DRV_IDLE;
                        wr_tag <= wr_tag + mem_pkg::tag_t'(1);
                    end
                end
                default:
                    state <= DRV_IDLE;
            endcase

            // Responses come back in order, so each must carry the tag we expect
            // A mismatch is recorded and held until reset
            if (rsp_valid)
            begin
                if (rsp.op == mem_pkg::OP_READ)
                begin
                    if (rsp.tag != rd_rsp_tag)
                        tag_error <= 1'b1;
                    if (rsp.last)
                        rd_rsp_tag <= rd_rsp_tag + mem_pkg::tag_t'(1);
                end
                else
                begin
                    // Every write ack moves the expected write tag on by one
                    if (rsp.tag != wr_rsp_tag)
                        tag_error <= 1'b1;
                    wr_rsp_tag <= wr_rsp_tag + mem_pkg::tag_t'(1);
                end
            end
        end
    end

    // Address, data and line count of the request being issued
    always_ff @(posedge clk)
    begin
        if (rdy && rd_en)
        begin
            cur_addr   <= rd_req.addr;
            lines_left <= burst_len;
        end
        else if (rdy && wr_en)
        begin
            cur_addr <= wr_req.addr;
            wr_data  <= wr_req.data;
        end
        else if ((state == DRV_READ_BURST) && grant)
        begin
            // Step to the next line of the burst, wrapping at the top of memory
            cur_addr   <= cur_addr + mem_pkg::addr_t'(1);
            lines_left <= lines_left - mem_pkg::len_t'(1);
        end
    end

    // ============================================================
    // Response decode
    // ============================================================

    assign rd_data  = rsp.data;
    assign rd_valid = rsp_valid && (rsp.op == mem_pkg::OP_READ);
    assign rd_last  = rd_valid && rsp.last;
    assign wr_ack   = rsp_valid && (rsp.op == mem_pkg::OP_WRITE);

endmodule

/* design/mem_arbiter.sv */
// Two ports only; assumes the memory answers every granted request exactly one cycle later
module mem_arbiter
(
    input  logic              clk,
    input  logic              reset,

    // Driver requests and grants
    input  mem_pkg::mem_req_t req0,
    input  logic              req_valid0,
    output logic              grant0,
    input  mem_pkg::mem_req_t req1,
    input  logic              req_valid1,
    output logic              grant1,

    // Memory side
    output mem_pkg::mem_req_t mem_req,
    output logic              mem_valid,
    input  mem_pkg::mem_rsp_t mem_rsp,
    input  logic              mem_rsp_valid,

    // Responses back to the drivers
    output mem_pkg::mem_rsp_t rsp0,
    output logic              rsp_valid0,
    output mem_pkg::mem_rsp_t rsp1,
    output logic              rsp_valid1
);

    // Set when port 1 won the most recent grant
    logic last_grant1;

    // Port that owns the response arriving this cycle
    logic rsp_sel1;

    // ============================================================
    // Grant
    // ============================================================

    // A lone requester always wins
    // When both request, the port granted last time waits
    assign grant0 = req_valid0 && (!req_valid1 || last_grant1);
    assign grant1 = req_valid1 && (!req_valid0 || !last_grant1);

    assign mem_req   = grant1 ? req1 : req0;
    assign mem_valid = grant0 || grant1;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Port 0 goes first after reset
            last_grant1 <= 1'b1;
            rsp_sel1    <= 1'b0;
        end
        else
        begin
            if (mem_valid)
                last_grant1 <= grant1;
            // The memory has one cycle of latency, so this owner matches its response
            rsp_sel1 <= grant1;
        end
    end

    // ============================================================
    // Response routing
    // ============================================================

    // Payload goes to both drivers, only the owner sees a valid strobe
    assign rsp0       = mem_rsp;
    assign rsp1       = mem_rsp;
    assign rsp_valid0 = mem_rsp_valid && !rsp_sel1;
    assign rsp_valid1 = mem_rsp_valid && rsp_sel1;

endmodule

/* design/mem_subsystem_top.sv */
// Clients must hold enable low while their rdy is low; responses and acks have no back-pressure
module mem_subsystem_top
#(
    parameter int NUM_LINES = 64,
    parameter int BURST_MAX = 4
)
(
    input  logic             clk,
    input  logic             reset,

    // ============================================================
    // Port 0
    // ============================================================
    input  mem_pkg::rd_req_t rd_req_0,
    input  logic             rd_en_0,
    input  mem_pkg::wr_req_t wr_req_0,
    input  logic             wr_en_0,
    output logic             rdy_0,
    output mem_pkg::line_t   rd_data_0,
    output logic             rd_valid_0,
    output logic             rd_last_0,
    output logic             wr_ack_0,
    output logic             tag_error_0,

    // ============================================================
    // Port 1
    // ============================================================
    input  mem_pkg::rd_req_t rd_req_1,
    input  logic             rd_en_1,
    input  mem_pkg::wr_req_t wr_req_1,
    input  logic             wr_en_1,
    output logic             rdy_1,
    output mem_pkg::line_t   rd_data_1,
    output logic             rd_valid_1,
    output logic             rd_last_1,
    output logic             wr_ack_1,
    output logic             tag_error_1
);

    // Driver to arbiter
    mem_pkg::mem_req_t req_0;
    mem_pkg::mem_req_t req_1;
    logic              req_valid_0;
    logic              req_valid_1;
    logic              grant_0;
    logic              grant_1;

    // Arbiter back to driver
    mem_pkg::mem_rsp_t rsp_0;
    mem_pkg::mem_rsp_t rsp_1;
    logic              rsp_valid_0;
    logic              rsp_valid_1;

    // Arbiter to memory and back
    mem_pkg::mem_req_t mem_req;
    logic              mem_valid;
    mem_pkg::mem_rsp_t mem_rsp;
    logic              mem_rsp_valid;

    mem_driver #(.BURST_MAX(BURST_MAX)) u_drv0
    (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req_0),
        .rd_en     (rd_en_0),
        .wr_req    (wr_req_0),
        .wr_en     (wr_en_0),
        .rdy       (rdy_0),
        .rd_data   (rd_data_0),
        .rd_valid  (rd_valid_0),
        .rd_last   (rd_last_0),
        .wr_ack    (wr_ack_0),
        .tag_error (tag_error_0),
        .req       (req_0),
        .req_valid (req_valid_0),
        .grant     (grant_0),
        .rsp       (rsp_0),
        .rsp_valid (rsp_valid_0)
    );

    mem_driver #(.BURST_MAX(BURST_MAX)) u_drv1
    (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req_1),
        .rd_en     (rd_en_1),
        .wr_req    (wr_req_1),
        .wr_en     (wr_en_1),
        .rdy       (rdy_1),
        .rd_data   (rd_data_1),
        .rd_valid  (rd_valid_1),
        .rd_last   (rd_last_1),
        .wr_ack    (wr_ack_1),
        .tag_error (tag_error_1),
        .req       (req_1),
        .req_valid (req_valid_1),
        .grant     (grant_1),
        .rsp       (rsp_1),
        .rsp_valid (rsp_valid_1)
    );

    mem_arbiter u_arb
    (
        .clk           (clk),
        .reset         (reset),
        .req0          (req_0),
        .req_valid0    (req_valid_0),
        .grant0        (grant_0),
        .req1          (req_1),
        .req_valid1    (req_valid_1),
        .grant1        (grant_1),
        .mem_req       (mem_req),
        .mem_valid     (mem_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .rsp0          (rsp_0),
        .rsp_valid0    (rsp_valid_0),
        .rsp1          (rsp_1),
        .rsp_valid1    (rsp_valid_1)
    );

    line_memory #(.NUM_LINES(NUM_LINES)) u_mem
    (
        .clk       (clk),
        .reset     (reset),
        .req       (mem_req),
        .req_valid (mem_valid),
        .rsp       (mem_rsp),
        .rsp_valid (mem_rsp_valid)
    );

endmodule

/* testbench/mem_props.sv */
// Protocol properties bound into mem_subsystem_top; they hold only outside reset
module mem_props
(
    input logic clk,
    input logic reset,
    input logic rdy_0,
    input logic rd_en_0,
    input logic wr_en_0,
    input logic rd_valid_0,
    input logic wr_ack_0,
    input logic rdy_1,
    input logic rd_en_1,
    input logic wr_en_1,
    input logic rd_valid_1,
    input logic wr_ack_1,
    input logic grant_0,
    input logic grant_1
);
    timeunit 1ns;
    timeprecision 1ps;

    // ============================================================
    // Client handshake
    // ============================================================

    // A busy driver must not be handed a new request
    a_en_busy_0: assert property (@(posedge clk) disable iff (reset)
        !rdy_0 |-> !(rd_en_0 || wr_en_0)) else $error("port 0 enable while busy");
    a_en_busy_1: assert property (@(posedge clk) disable iff (reset)
        !rdy_1 |-> !(rd_en_1 || wr_en_1)) else $error("port 1 enable while busy");

    // One memory response per cycle means read data and write ack cannot coincide
    a_rsp_excl_0: assert property (@(posedge clk) disable iff (reset)
        !(rd_valid_0 && wr_ack_0)) else $error("port 0 read and ack together");
    a_rsp_excl_1: assert property (@(posedge clk) disable iff (reset)
        !(rd_valid_1 && wr_ack_1)) else $error("port 1 read and ack together");

    // ============================================================
    // Arbiter
    // ============================================================

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        !(grant_0 && grant_1)) else $error("both grants high");

endmodule

bind mem_subsystem_top mem_props u_props
(
    .clk (clk), .reset (reset),
    .rdy_0 (rdy_0), .rd_en_0 (rd_en_0), .wr_en_0 (wr_en_0),
    .rd_valid_0 (rd_valid_0), .wr_ack_0 (wr_ack_0),
    .rdy_1 (rdy_1), .rd_en_1 (rd_en_1), .wr_en_1 (wr_en_1),
    .rd_valid_1 (rd_valid_1), .wr_ack_1 (wr_ack_1),
    .grant_0 (grant_0), .grant_1 (grant_1)
);

/* testbench/mem_tb.sv */
// Testbench for mem_subsystem_top; fills all 64 lines first, port regions are split in the random test
module mem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RAND = 40;
    // Fill, write and read of test 1, then tests 2 to 5
    localparam int N_OPS = 66 + 1 + 2 * N_RAND + 2 + 1;
    localparam int WATCHDOG_CYCLES = N_OPS * 40 + 500;

    // Expected read line, checked against the model when it arrives
    typedef struct packed {
        mem_pkg::addr_t addr;
        logic           last;
    } exp_rd_t;

    logic clk;
    logic reset;
    mem_pkg::rd_req_t rd_req_0, rd_req_1;
    mem_pkg::wr_req_t wr_req_0, wr_req_1;
    logic rd_en_0, wr_en_0, rd_en_1, wr_en_1;
    logic rdy_0, rd_valid_0, rd_last_0, wr_ack_0, tag_error_0;
    logic rdy_1, rd_valid_1, rd_last_1, wr_ack_1, tag_error_1;
    mem_pkg::line_t rd_data_0, rd_data_1;

    mem_pkg::line_t   model [64];
    exp_rd_t          exp_q [2][$];
    mem_pkg::wr_req_t pend_q [2][$];
    int ack_cnt [2];
    int wr_issued [2];
    int issue_cyc [2];
    int rd_cycle [2];
    int cyc;
    int checks;
    int errors;

    mem_subsystem_top #(.NUM_LINES(64), .BURST_MAX(4)) u_dut
    (
        .clk (clk), .reset (reset),
        .rd_req_0 (rd_req_0), .rd_en_0 (rd_en_0), .wr_req_0 (wr_req_0), .wr_en_0 (wr_en_0),
        .rdy_0 (rdy_0), .rd_data_0 (rd_data_0), .rd_valid_0 (rd_valid_0),
        .rd_last_0 (rd_last_0), .wr_ack_0 (wr_ack_0), .tag_error_0 (tag_error_0),
        .rd_req_1 (rd_req_1), .rd_en_1 (rd_en_1), .wr_req_1 (wr_req_1), .wr_en_1 (wr_en_1),
        .rdy_1 (rdy_1), .rd_data_1 (rd_data_1), .rd_valid_1 (rd_valid_1),
        .rd_last_1 (rd_last_1), .wr_ack_1 (wr_ack_1), .tag_error_1 (tag_error_1)
    );

    // ============================================================
    // Clock, cycle count and watchdog
    // ============================================================

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    // ============================================================
    // Reference model and compare tasks
    // ============================================================

    // Expected contents of a line, as last acknowledged by the DUT
    function automatic mem_pkg::line_t ref_line(input mem_pkg::addr_t a);
        return model[a];
    endfunction

    // Initial contents, every address bit shows up twice
    function automatic mem_pkg::line_t fill_line(input mem_pkg::addr_t a);
        return {16'hF00D, 10'h000, a, 16'hBEEF, 10'h3FF, ~a};
    endfunction

    task automatic compare_line(input mem_pkg::line_t got, input mem_pkg::line_t exp,
                                input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Checks one port's responses, in request order
    task automatic check_port(input int p, input logic valid, input mem_pkg::line_t data,
                              input logic last, input logic ack);
        exp_rd_t          e;
        mem_pkg::wr_req_t w;
        if (valid)
        begin
            rd_cycle[p] = cyc;
            if (exp_q[p].size() == 0)
            begin
                errors++;
                $display("Error at %0t: port %0d returned read data nobody asked for", $time, p);
            end
            else
            begin
                e = exp_q[p].pop_front();
                compare_line(data, ref_line(e.addr),
                             $sformatf("port %0d line at 0x%0h", p, e.addr));
                compare_flag(last, e.last, $sformatf("port %0d rd_last at 0x%0h", p, e.addr));
            end
        end
        if (ack)
        begin
            // Every ack pulse counts, expected or not
            ack_cnt[p]++;
            if (pend_q[p].size() == 0)
            begin
                errors++;
                $display("Error at %0t: port %0d acknowledged a write it never got", $time, p);
            end
            else
            begin
                // The line is in memory once the ack shows up
                w = pend_q[p].pop_front();
                model[w.addr] = w.data;
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_port(0, rd_valid_0, rd_data_0, rd_last_0, wr_ack_0);
            check_port(1, rd_valid_1, rd_data_1, rd_last_1, wr_ack_1);
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================

    // Drives at the first rising edge after rdy was seen high with enable low,
    // so the request is taken at the edge after that
    task automatic issue_read(input int p, input mem_pkg::addr_t a, input mem_pkg::len_t n);
        exp_rd_t e;
        @(negedge clk);
        while (!(p == 0 ? rdy_0 : rdy_1))
            @(negedge clk);
        @(posedge clk);
        if (p == 0)
        begin
            rd_req_0 <= '{addr: a, num_lines: n};
            rd_en_0  <= 1'b1;
        end
        else
        begin
            rd_req_1 <= '{addr: a, num_lines: n};
            rd_en_1  <= 1'b1;
        end
        for (int k = 0; k <= int'(n); k++)
        begin
            e.addr = a + mem_pkg::addr_t'(k);
            e.last = (k == int'(n));
            exp_q[p].push_back(e);
        end
        @(negedge clk);
        issue_cyc[p] = cyc;
        @(posedge clk);
        if (p == 0)
            rd_en_0 <= 1'b0;
        else
            rd_en_1 <= 1'b0;
    endtask

    task automatic issue_write(input int p, input mem_pkg::addr_t a, input mem_pkg::line_t d);
        mem_pkg::wr_req_t w;
        w = '{addr: a, data: d};
        @(negedge clk);
        while (!(p == 0 ? rdy_0 : rdy_1))
            @(negedge clk);
        @(posedge clk);
        if (p == 0)
        begin
            wr_req_0 <= w;
            wr_en_0  <= 1'b1;
        end
        else
        begin
            wr_req_1 <= w;
            wr_en_1  <= 1'b1;
        end
        pend_q[p].push_back(w);
        wr_issued[p]++;
        @(posedge clk);
        if (p == 0)
            wr_en_0 <= 1'b0;
        else
            wr_en_1 <= 1'b0;
    endtask

    // Every issued request has an entry, so empty queues mean all responses are in
    task automatic wait_idle();
        @(posedge clk);
        while (exp_q[0].size() + exp_q[1].size() + pend_q[0].size() + pend_q[1].size() != 0)
            @(posedge clk);
    endtask

    // Port 0 stays in lines 0 to 31 and port 1 in 32 to 63, so the ports never race
    task automatic run_random(input int p);
        int base;
        base = p * 32;
        for (int i = 0; i < N_RAND; i++)
        begin
            if ($urandom_range(1, 0) == 1)
                issue_write(p, mem_pkg::addr_t'(base + int'($urandom_range(31, 0))),
                            mem_pkg::line_t'({$urandom, $urandom}));
            else
                issue_read(p, mem_pkg::addr_t'(base + int'($urandom_range(28, 0))),
                           mem_pkg::len_t'($urandom_range(3, 0)));
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "errors found");
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        int unsigned seed_val;
        int e0;
        int ack0;
        int ack1;
        mem_pkg::line_t d;
        seed_val = $urandom(44476);
        cyc = 0;
        checks = 0;
        errors = 0;
        reset = 1'b1;
        rd_req_0 = '0;
        rd_req_1 = '0;
        wr_req_0 = '0;
        wr_req_1 = '0;
        rd_en_0 = 1'b0;
        wr_en_0 = 1'b0;
        rd_en_1 = 1'b0;
        wr_en_1 = 1'b0;
        for (int i = 0; i < 2; i++)
        begin
            ack_cnt[i] = 0;
            wr_issued[i] = 0;
            issue_cyc[i] = 0;
            rd_cycle[i] = 0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Test 1: idle outputs after reset, fill, then a write and read back
        e0 = errors;
        @(negedge clk);
        compare_flag(rdy_0, 1'b1, "rdy_0 after reset");
        compare_flag(rdy_1, 1'b1, "rdy_1 after reset");
        compare_flag(rd_valid_0 | rd_valid_1, 1'b0, "rd_valid after reset");
        compare_flag(wr_ack_0 | wr_ack_1, 1'b0, "wr_ack after reset");
        compare_flag(tag_error_0 | tag_error_1, 1'b0, "tag_error after reset");
        for (int a = 0; a < 64; a++)
            issue_write(0, mem_pkg::addr_t'(a), fill_line(mem_pkg::addr_t'(a)));
        issue_write(0, mem_pkg::addr_t'(9), mem_pkg::line_t'({$urandom, $urandom}));
        issue_read(0, mem_pkg::addr_t'(9), mem_pkg::len_t'(0));
        wait_idle();
        end_test("test 1 reset state and write-read", e0);

        // Test 2: four-line burst, rd_last is checked per line by the monitor
        e0 = errors;
        issue_read(1, mem_pkg::addr_t'(20), mem_pkg::len_t'(3));
        wait_idle();
        end_test("test 2 four-line burst", e0);

        // Test 3: both ports at once
        e0 = errors;
        ack0 = ack_cnt[0] - wr_issued[0];
        ack1 = ack_cnt[1] - wr_issued[1];
        fork
            run_random(0);
            run_random(1);
        join
        wait_idle();
        compare_count(ack_cnt[0] - wr_issued[0], ack0, "port 0 acks against writes");
        compare_count(ack_cnt[1] - wr_issued[1], ack1, "port 1 acks against writes");
        end_test("test 3 random traffic on both ports", e0);

        // Test 4: port 1 sees what port 0 wrote
        e0 = errors;
        d = mem_pkg::line_t'({$urandom, $urandom});
        issue_write(0, mem_pkg::addr_t'(40), d);
        wait_idle();
        issue_read(1, mem_pkg::addr_t'(40), mem_pkg::len_t'(0));
        wait_idle();
        end_test("test 4 cross-port visibility", e0);

        // Test 5: the response lands two cycles after the cycle rd_en was taken
        e0 = errors;
        issue_read(0, mem_pkg::addr_t'(3), mem_pkg::len_t'(0));
        wait_idle();
        compare_count(rd_cycle[0] - issue_cyc[0], 2, "uncontended read latency");
        end_test("test 5 uncontended timing", e0);

        // Test 6: tag_error is sticky, so one look at the end covers the run
        e0 = errors;
        compare_flag(tag_error_0, 1'b0, "tag_error_0");
        compare_flag(tag_error_1, 1'b0, "tag_error_1");
        end_test("test 6 no tag errors", e0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* sources.f */
design/mem_pkg.sv
design/line_memory.sv
design/mem_driver.sv
design/mem_arbiter.sv
design/mem_subsystem_top.sv
testbench/mem_props.sv
testbench/mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module mem_tb \
    -o mem_tb_sim --Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/mem_tb_sim > sim.log 2>&1 ; cat sim.log 2>/dev/null ; \
grep -qx "all tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
